/* vlsu_config.svh */
`ifndef VLSU_CONFIG_SVH
`define VLSU_CONFIG_SVH

// Byte address into the banked memory
`define VLSU_ADDR_W 14

// Four banks interleaved by word
`define VLSU_NBANK 4

// Bank word width
`define VLSU_WORD_W 32

// Vector register width
`define VLSU_VLEN 512

// Row above the bank select and byte bits
`define VLSU_ROW_W (`VLSU_ADDR_W - 4)

// 64 byte elements in four lanes
`define VLSU_MAX_BEATS 16

`endif

/* vlsu_isa_pkg.sv */
`include "vlsu_config.svh"

package vlsu_isa_pkg;

    // Element width of the VLE and VSE ops
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,     // Byte elements
        EEW_16 = 2'd1,     // Halfword elements
        EEW_32 = 2'd2      // Word elements
    } eew_e;

    // LMUL code with the transfer length it selects
    typedef enum logic [2:0] {
        LMUL_1    = 3'b000,    // 128 bits
        LMUL_2    = 3'b001,    // 256 bits
        LMUL_4    = 3'b010,    // Full 512 bits
        LMUL_HALF = 3'b111     // 64 bits
    } lmul_e;                  // Other codes give 32 bits

    // Whole vector register
    typedef logic [`VLSU_VLEN-1:0] vreg_t;

    // Transfer length in bits, 32 up to VLEN
    typedef logic [$clog2(`VLSU_VLEN):0] vbits_t;

    // Element count, up to VLEN over 8
    typedef logic [$clog2(`VLSU_VLEN/8):0] ecount_t;

endpackage

/* vlsu_mem_pkg.sv */
`include "vlsu_config.svh"

package vlsu_mem_pkg;

    // Data word of one bank
    typedef logic [`VLSU_WORD_W-1:0] word_t;

    // Bank row from address bits above 3
    typedef logic [`VLSU_ROW_W-1:0] row_t;

    // One bit per bank or per lane
    typedef logic [`VLSU_NBANK-1:0] lane_mask_t;

    // Beat index, wide enough to count past the last beat
    typedef logic [$clog2(`VLSU_MAX_BEATS+1)-1:0] beat_t;

endpackage

/* vlsu_ctrl.sv */
`timescale 1ns/10ps
`include "vlsu_config.svh"

module vlsu_ctrl
    import vlsu_isa_pkg::*;
    import vlsu_mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   start,
    input  logic                   op_store,
    input  eew_e                   eew,
    input  lmul_e                  lmul,
    input  logic [`VLSU_ADDR_W-1:0] base_addr,
    output row_t                   bank_row [`VLSU_NBANK],
    output logic                   bank_re,
    output logic                   load_beat,
    output logic                   store_beat,
    output logic                   load_last,
    output beat_t                  beat_idx,
    output lane_mask_t             lane_en,
    output logic [1:0]             word_off,
    output eew_e                   eew_q,
    output logic                   busy,
    output logic                   done
);

    logic       run;          // Beats being issued
    logic       ld_wait;      // Last load beat still in memory
    logic       accept;       // Command taken this cycle
    logic       last_beat;    // Current beat is the final one
    logic       op_q;         // Held op, high for store
    eew_e       eew_r;        // Held element width
    ecount_t    cnt_q;        // Held element count
    beat_t      nbeat_q;      // Held beat count
    beat_t      beat_cnt;     // Beat now issued
    row_t       row_q;        // Row of the base word
    logic [1:0] off_q;        // Bank of the base word
    vbits_t     xfer_bits;    // Transfer length of new command
    ecount_t    cnt_d;        // Element count of new command
    beat_t      nbeat_d;      // Beat count of new command

    assign accept = start && !busy;    // Start while busy is dropped

    // Transfer length from the LMUL code
    always_comb
    begin
        case (lmul)
            LMUL_1:    xfer_bits = vbits_t'(128);
            LMUL_2:    xfer_bits = vbits_t'(256);
            LMUL_4:    xfer_bits = vbits_t'(512);
            LMUL_HALF: xfer_bits = vbits_t'(64);
            default:   xfer_bits = vbits_t'(32);    // Undefined codes
        endcase
    end

    // Elements are transfer bits over element width
    always_comb
    begin
        case (eew)
            EEW_8:   cnt_d = ecount_t'(xfer_bits >> 3);
            EEW_16:  cnt_d = ecount_t'(xfer_bits >> 4);
            default: cnt_d = ecount_t'(xfer_bits >> 5);
        endcase
        nbeat_d = beat_t'((cnt_d + 3) >> 2);    // Four lanes a beat, rounded up
    end

    // Command fields, loaded only on accept
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q    <= op_store;
            eew_r   <= eew;
            cnt_q   <= cnt_d;
            nbeat_q <= nbeat_d;
            row_q   <= base_addr[`VLSU_ADDR_W-1:4];
            off_q   <= base_addr[3:2];    // Byte bits ignored
        end
    end

    // Beat sequencing and done
    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            run      <= 1'b0;
            ld_wait  <= 1'b0;
            done     <= 1'b0;
            beat_cnt <= '0;
        end
        else
        begin
            ld_wait <= load_last;                           // Data of last beat in flight
            done    <= ld_wait || (store_beat && last_beat); // Store ends one cycle earlier
            if (accept)
            begin
                run      <= 1'b1;    // First beat next cycle
                beat_cnt <= '0;
            end
            else if (run)
            begin
                if (last_beat)
                    run <= 1'b0;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    assign last_beat  = (beat_cnt == nbeat_q - 1'b1);
    assign load_beat  = run && !op_q;
    assign store_beat = run && op_q;
    assign load_last  = load_beat && last_beat;
    assign bank_re    = load_beat;
    assign busy       = run || ld_wait || done;    // Through the done cycle

    // Lane j carries element 4b+j while below the count
    always_comb
    begin
        for (int j = 0; j < `VLSU_NBANK; j++)
            lane_en[j] = ({beat_cnt[3:0], 2'(j)} < cnt_q);
    end

    // Banks below the offset already wrapped into the next row
    always_comb
    begin
        for (int k = 0; k < `VLSU_NBANK; k++)
            bank_row[k] = row_q + row_t'(beat_cnt) + ((k < off_q) ? row_t'(1) : row_t'(0));
    end

    assign beat_idx = beat_cnt;
    assign word_off = off_q;
    assign eew_q    = eew_r;

endmodule

/* vlsu_load_packer.sv */
`timescale 1ns/10ps
`include "vlsu_config.svh"

module vlsu_load_packer
    import vlsu_isa_pkg::*;
    import vlsu_mem_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       load_beat,
    input  logic       load_last,
    input  beat_t      beat_idx,
    input  lane_mask_t lane_en,
    input  logic [1:0] word_off,
    input  eew_e       eew_q,
    input  word_t      bank_rdata [`VLSU_NBANK],
    output vreg_t      vd_data
);

    logic       beat_v;                    // Read data returns this cycle
    logic       last_v;                    // Returning beat is the last
    beat_t      beat_d;                    // Beat index of returning data
    lane_mask_t lane_d;                    // Lanes holding elements
    logic [1:0] off_d;                     // Rotation of returning data
    eew_e       eew_d;                     // Element width of returning data
    word_t      lane_word [`VLSU_NBANK];   // Bank words in lane order
    vreg_t      work;                      // Result under construction
    vreg_t      work_nxt;                  // Working register with this beat merged

    // Match the one cycle read latency
    always_ff @(posedge clk)
    begin
        if (!nrst)
        begin
            beat_v <= 1'b0;
            last_v <= 1'b0;
        end
        else
        begin
            beat_v <= load_beat;
            last_v <= load_last;
        end
    end

    always_ff @(posedge clk)
    begin
        beat_d <= beat_idx;
        lane_d <= lane_en;
        off_d  <= word_off;
        eew_d  <= eew_q;
    end

    // Lane j reads bank (offset+j) mod 4
    always_comb
    begin
        for (int j = 0; j < `VLSU_NBANK; j++)
            lane_word[j] = bank_rdata[2'(off_d + j)];
    end

    // Merge low eew bits of each lane into element 4b+j
    always_comb
    begin
        logic [5:0] idx;    // Element number of the lane

        work_nxt = (beat_d == '0) ? '0 : work;    // Fresh result on first beat
        for (int j = 0; j < `VLSU_NBANK; j++)
        begin
            idx = {beat_d[3:0], 2'(j)};
            if (lane_d[j])
            begin
                case (eew_d)
                    EEW_8:   work_nxt[idx*8 +: 8]        = lane_word[j][7:0];
                    EEW_16:  work_nxt[idx[4:0]*16 +: 16] = lane_word[j][15:0];
                    default: work_nxt[idx[3:0]*32 +: 32] = lane_word[j];
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_v)
            work <= work_nxt;
    end

    // Result stays put while the next load fills work
    always_ff @(posedge clk)
    begin
        if (!nrst)
            vd_data <= '0;
        else if (last_v)
            vd_data <= work_nxt;
    end

endmodule

/* vlsu_store_slicer.sv */
`timescale 1ns/10ps
`include "vlsu_config.svh"

module vlsu_store_slicer
    import vlsu_isa_pkg::*;
    import vlsu_mem_pkg::*;
(
    input  logic       store_beat,
    input  beat_t      beat_idx,
    input  lane_mask_t lane_en,
    input  logic [1:0] word_off,
    input  eew_e       eew_q,
    input  vreg_t      vs_data,
    output word_t      bank_wdata [`VLSU_NBANK],
    output lane_mask_t bank_we
);

    word_t lane_word [`VLSU_NBANK];    // Sign extended elements in lane order

    // Elements 4b to 4b+3 of the source register
    always_comb
    begin
        logic [5:0]  idx;    // Element number of the lane
        logic [7:0]  e8;
        logic [15:0] e16;

        for (int j = 0; j < `VLSU_NBANK; j++)
        begin
            idx = {beat_idx[3:0], 2'(j)};
            e8  = vs_data[idx*8 +: 8];
            e16 = vs_data[idx[4:0]*16 +: 16];    // Halfwords stop at element 31
            case (eew_q)
                EEW_8:
                begin
                    lane_word[j] = {{(`VLSU_WORD_W-8){e8[7]}}, e8};
                end
                EEW_16:
                begin
                    lane_word[j] = {{(`VLSU_WORD_W-16){e16[15]}}, e16};
                end
                default:
                begin
                    lane_word[j] = vs_data[idx[3:0]*32 +: 32];    // Full word, no extension
                end
            endcase
        end
    end

    // Bank k takes lane (k - offset) mod 4
    always_comb
    begin
        logic [1:0] lane;

        for (int k = 0; k < `VLSU_NBANK; k++)
        begin
            lane          = 2'(k - word_off);
            bank_wdata[k] = lane_word[lane];
            bank_we[k]    = store_beat && lane_en[lane];    // Disabled lanes leave memory alone
        end
    end

endmodule

/* vlsu_top.sv */
`timescale 1ns/10ps
`include "vlsu_config.svh"

module vlsu_top
    import vlsu_isa_pkg::*;
    import vlsu_mem_pkg::*;
(
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    start,
    input  logic                    op_store,
    input  eew_e                    eew,
    input  lmul_e                   lmul,
    input  logic [`VLSU_ADDR_W-1:0] base_addr,
    input  vreg_t                   vs_data,
    input  word_t                   bank_rdata [`VLSU_NBANK],
    output row_t                    bank_row [`VLSU_NBANK],
    output logic                    bank_re,
    output lane_mask_t              bank_we,
    output word_t                   bank_wdata [`VLSU_NBANK],
    output vreg_t                   vd_data,
    output logic                    busy,
    output logic                    done
);

    logic       load_beat;     // Read beat issued
    logic       store_beat;    // Write beat issued
    logic       load_last;     // Final read beat
    beat_t      beat_idx;
    lane_mask_t lane_en;       // Lanes with elements this beat
    logic [1:0] word_off;      // Bank of the base word
    eew_e       eew_q;

    vlsu_ctrl u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .op_store   (op_store),
        .eew        (eew),
        .lmul       (lmul),
        .base_addr  (base_addr),
        .bank_row   (bank_row),
        .bank_re    (bank_re),
        .load_beat  (load_beat),
        .store_beat (store_beat),
        .load_last  (load_last),
        .beat_idx   (beat_idx),
        .lane_en    (lane_en),
        .word_off   (word_off),
        .eew_q      (eew_q),
        .busy       (busy),
        .done       (done)
    );

    vlsu_load_packer u_load_packer (
        .clk        (clk),
        .nrst       (nrst),
        .load_beat  (load_beat),
        .load_last  (load_last),
        .beat_idx   (beat_idx),
        .lane_en    (lane_en),
        .word_off   (word_off),
        .eew_q      (eew_q),
        .bank_rdata (bank_rdata),
        .vd_data    (vd_data)
    );

    vlsu_store_slicer u_store_slicer (
        .store_beat (store_beat),
        .beat_idx   (beat_idx),
        .lane_en    (lane_en),
        .word_off   (word_off),
        .eew_q      (eew_q),
        .vs_data    (vs_data),
        .bank_wdata (bank_wdata),
        .bank_we    (bank_we)
    );

endmodule

/* tb_vlsu_mem.sv */
`timescale 1ns/10ps
`include "vlsu_config.svh"

module tb_vlsu_mem
    import vlsu_isa_pkg::*;
    import vlsu_mem_pkg::*;
(
    input  logic       clk,
    input  row_t       bank_row [`VLSU_NBANK],
    input  logic       bank_re,
    input  lane_mask_t bank_we,
    input  word_t      bank_wdata [`VLSU_NBANK],
    output word_t      bank_rdata [`VLSU_NBANK]
);

    localparam int ROWS  = 1 << `VLSU_ROW_W;    // 1024 rows per bank
    localparam int WORDS = ROWS * `VLSU_NBANK;

    word_t mem [`VLSU_NBANK][ROWS];    // Banks as the DUT sees them
    word_t model_mem [WORDS];          // Expected image, flat by word address

    initial
    begin
        for (int k = 0; k < `VLSU_NBANK; k++)
            bank_rdata[k] <= '0;
    end

    // Read data one cycle after bank_re, writes land at the edge
    always @(posedge clk)
    begin
        for (int k = 0; k < `VLSU_NBANK; k++)
        begin
            if (bank_we[k])
                mem[k][bank_row[k]] <= bank_wdata[k];
            if (bank_re)
                bank_rdata[k] <= mem[k][bank_row[k]];
        end
    end

    // Same value into the banks and the model image
    task automatic preload(input int w, input word_t v);
        mem[w % `VLSU_NBANK][w / `VLSU_NBANK] <= v;
        model_mem[w] = v;
    endtask

    // Word address w lives in bank w mod 4, row w / 4
    function automatic word_t bank_word(input int w);
        return mem[w % `VLSU_NBANK][w / `VLSU_NBANK];
    endfunction

    function automatic int elem_bits(input eew_e e);
        case (e)
            EEW_8:   return 8;
            EEW_16:  return 16;
            default: return 32;
        endcase
    endfunction

    // Transfer bits from the LMUL table over element width
    function automatic int model_count(input eew_e e, input lmul_e l);
        int bits;

        case (l)
            3'b000:  bits = 128;
            3'b001:  bits = 256;
            3'b010:  bits = 512;
            3'b111:  bits = 64;
            default: bits = 32;    // Undefined codes
        endcase
        return bits / elem_bits(e);
    endfunction

    // Element i from word base+i, zeros above the count
    function automatic vreg_t expect_load(input int base_w, input eew_e e, input int cnt);
        vreg_t v;
        word_t w;
        int    ew;

        v  = '0;
        ew = elem_bits(e);
        for (int i = 0; i < cnt; i++)
        begin
            w = model_mem[(base_w + i) % WORDS];    // Wraps at the top of memory
            for (int k = 0; k < ew; k++)
                v[i*ew + k] = w[k];
        end
        return v;
    endfunction

    task automatic apply_store(input int base_w, input eew_e e, input int cnt, input vreg_t src);
        word_t w;
        int    ew;

        ew = elem_bits(e);
        for (int i = 0; i < cnt; i++)
        begin
            for (int k = 0; k < `VLSU_WORD_W; k++)
                w[k] = (k < ew) ? src[i*ew + k] : src[i*ew + ew - 1];    // Sign bit fills up
            model_mem[(base_w + i) % WORDS] = w;
        end
    endtask

endmodule

/* tb_vlsu.sv */
`timescale 1ns/10ps
`include "vlsu_config.svh"

module tb_vlsu
    import vlsu_isa_pkg::*;
    import vlsu_mem_pkg::*;
();

    localparam int WORDS   = (1 << `VLSU_ROW_W) * `VLSU_NBANK;
    localparam int TIMEOUT = 200;    // Cycles allowed per transfer

    logic                    clk;
    logic                    nrst;
    logic                    start;
    logic                    op_store;
    eew_e                    eew;
    lmul_e                   lmul;
    logic [`VLSU_ADDR_W-1:0] base_addr;
    vreg_t                   vs_data;
    word_t                   bank_rdata [`VLSU_NBANK];
    row_t                    bank_row [`VLSU_NBANK];
    logic                    bank_re;
    lane_mask_t              bank_we;
    word_t                   bank_wdata [`VLSU_NBANK];
    vreg_t                   vd_data;
    logic                    busy;
    logic                    done;

    logic [31:0] rng;          // LCG state
    int          checks;
    int          mismatches;
    int          timeouts;
    int          others;
    vreg_t       last_load;    // Result that vd_data should still show

    vlsu_top u_dut (
        .clk        (clk),
        .nrst       (nrst),
        .start      (start),
        .op_store   (op_store),
        .eew        (eew),
        .lmul       (lmul),
        .base_addr  (base_addr),
        .vs_data    (vs_data),
        .bank_rdata (bank_rdata),
        .bank_row   (bank_row),
        .bank_re    (bank_re),
        .bank_we    (bank_we),
        .bank_wdata (bank_wdata),
        .vd_data    (vd_data),
        .busy       (busy),
        .done       (done)
    );

    tb_vlsu_mem u_mem (
        .clk        (clk),
        .bank_row   (bank_row),
        .bank_re    (bank_re),
        .bank_we    (bank_we),
        .bank_wdata (bank_wdata),
        .bank_rdata (bank_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng ^ (rng >> 16);    // Fold high bits into the weak low ones
    endfunction

    // Whole memory against the model up to the first bad word
    task automatic check_image(input string name);
        logic bad;

        bad = 1'b0;
        checks++;
        for (int w = 0; w < WORDS && !bad; w++)
        begin
            if (u_mem.bank_word(w) !== u_mem.model_mem[w])
            begin
                bad = 1'b1;
                mismatches++;
                $display("Mismatch %s word %0d: expected %h, actual %h",
                         name, w, u_mem.model_mem[w], u_mem.bank_word(w));
            end
        end
    endtask

    task automatic run_cmd(input string name, input logic st, input eew_e e, input lmul_e l,
                           input logic [11:0] base_w, input logic spur);
        int          cnt;
        int          nbeat;
        int          cycles;
        int          exp_cycles;
        logic        got;
        logic        exp_re;
        vreg_t       src;
        vreg_t       exp_v;
        logic [31:0] r;

        cnt   = u_mem.model_count(e, l);
        nbeat = (cnt + 3) / 4;
        for (int i = 0; i < `VLSU_VLEN / 32; i++)
            src[i*32 +: 32] = rand32();
        r         = rand32();
        op_store  = st;
        eew       = e;
        lmul      = l;
        base_addr = {base_w, r[1:0]};    // Byte bits ignored by the DUT
        vs_data   = src;                 // Held until the next command
        start     = 1'b1;
        cycles    = 0;
        got       = 1'b0;
        while (!got && cycles < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
            checks++;
            if (busy !== 1'b1)
            begin
                mismatches++;
                $display("Mismatch %s busy in cycle %0d: expected 1, actual %b",
                         name, cycles, busy);
            end
            exp_re = !st && (cycles <= nbeat);    // Reads only in the beat cycles of a load
            checks++;
            if (bank_re !== exp_re)
            begin
                mismatches++;
                $display("Mismatch %s bank_re in cycle %0d: expected %b, actual %b",
                         name, cycles, exp_re, bank_re);
            end
            start = spur && (cycles == 2);    // Lands while busy
            if (start)
            begin
                r         = rand32();
                op_store  = ~st;
                eew       = eew_e'(2'(r[7:0] % 8'd3));
                lmul      = lmul_e'(r[10:8]);
                base_addr = r[`VLSU_ADDR_W+15:16];
            end
            got = done;
        end
        start = 1'b0;
        checks++;
        if (!got)
        begin
            timeouts++;
            $display("%s: done did not arrive within %0d cycles", name, TIMEOUT);
        end
        else
        begin
            exp_cycles = st ? nbeat + 1 : nbeat + 2;    // Loads wait one more for read data
            if (cycles != exp_cycles)
            begin
                mismatches++;
                $display("Mismatch %s done latency: expected %0d, actual %0d",
                         name, exp_cycles, cycles);
            end
            if (st)
            begin
                u_mem.apply_store(base_w, e, cnt, src);
                check_image(name);
                exp_v = last_load;    // Store leaves the load result alone
            end
            else
            begin
                exp_v     = u_mem.expect_load(base_w, e, cnt);
                last_load = exp_v;
            end
            checks++;
            if (vd_data !== exp_v)
            begin
                mismatches++;
                $display("Mismatch %s vd_data: expected %h, actual %h", name, exp_v, vd_data);
            end
        end
        @(posedge clk);
        #1;
        checks++;
        if (busy !== 1'b0 || done !== 1'b0)
        begin
            others++;
            $display("%s: busy or done still high the cycle after done", name);
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [11:0] bw;

        rng        = 32'd77;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        others     = 0;
        last_load  = '0;
        nrst       = 1'b0;
        start      = 1'b0;
        op_store   = 1'b0;
        eew        = EEW_8;
        lmul       = LMUL_1;
        base_addr  = '0;
        vs_data    = '0;
        for (int w = 0; w < WORDS; w++)
            u_mem.preload(w, rand32());
        repeat (16) @(posedge clk);
        #1;
        nrst = 1'b1;
        checks++;
        if (busy !== 1'b0 || done !== 1'b0 || bank_re !== 1'b0 || bank_we !== '0)
        begin
            others++;
            $display("reset: busy, done or a bank strobe is not low after reset");
        end
        checks++;
        if (vd_data !== '0)
        begin
            mismatches++;
            $display("Mismatch reset vd_data: expected %h, actual %h", vreg_t'(0), vd_data);
        end

        // Mixed loads and stores over every LMUL code
        for (int n = 0; n < 200; n++)
        begin
            r  = rand32();
            bw = r[27:16];
            run_cmd("random", r[0], eew_e'(2'(r[11:4] % 8'd3)), lmul_e'(r[14:12]), bw,
                    r[1] && r[2]);
        end

        // Offsets 1 to 3 cross a row and the last pair wraps the memory top
        for (int off = 1; off < 4; off++)
        begin
            r  = rand32();
            bw = {r[9:0], 2'(off)};
            run_cmd("offset", 1'b1, EEW_32, LMUL_1, bw, 1'b0);
            run_cmd("offset", 1'b0, EEW_32, LMUL_1, bw, 1'b0);
            run_cmd("offset", 1'b1, EEW_8, LMUL_4, bw, 1'b0);
            run_cmd("offset", 1'b0, EEW_16, LMUL_2, bw, 1'b0);
        end
        run_cmd("offset", 1'b1, EEW_16, LMUL_1, 12'hffe, 1'b0);
        run_cmd("offset", 1'b0, EEW_16, LMUL_1, 12'hffe, 1'b0);

        // One or two word transfers on every bank position
        for (int off = 0; off < 4; off++)
        begin
            r  = rand32();
            bw = {r[9:0], 2'(off)};
            run_cmd("short", 1'b1, EEW_32, LMUL_HALF, bw, 1'b0);
            run_cmd("short", 1'b0, EEW_32, LMUL_HALF, bw, 1'b0);
            run_cmd("short", 1'b1, EEW_32, lmul_e'(3'b011), bw, 1'b0);
            run_cmd("short", 1'b0, EEW_32, lmul_e'(3'b011), bw, 1'b0);
        end

        // Second start during every transfer
        for (int n = 0; n < 6; n++)
        begin
            r = rand32();
            run_cmd("busy_start", n[0], EEW_16, LMUL_1, r[11:0], 1'b1);
        end

        $display("checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
                 checks, mismatches, timeouts, others);
        if (mismatches + timeouts + others == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* vlsu.f */
+incdir+.
vlsu_isa_pkg.sv
vlsu_mem_pkg.sv
vlsu_ctrl.sv
vlsu_load_packer.sv
vlsu_store_slicer.sv
vlsu_top.sv
tb_vlsu_mem.sv
tb_vlsu.sv

/* Bender.yml */
package:
  name: vlsu

export_include_dirs:
  - .

sources:
  - files:
      - vlsu_isa_pkg.sv
      - vlsu_mem_pkg.sv
      - vlsu_ctrl.sv
      - vlsu_load_packer.sv
      - vlsu_store_slicer.sv
      - vlsu_top.sv
  - target: simulation
    files:
      - tb_vlsu_mem.sv
      - tb_vlsu.sv
